// File: common/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// address and data path widths.
`define MEM_ADDR_W 32
`define MEM_DATA_W 64

// direct-mapped cache, 8-byte lines.
`define MEM_LINES 16

`define MEM_TLB_ENTRIES 8

// 4 KB pages.
`define MEM_PAGE_W 20

// opaque control word passed to the next stage.
`define MEM_CTRL_W 32

`endif

// File: common/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // operand source select.
    typedef enum logic [2:0] {
        SRC_REG1 = 3'd0,
        SRC_REG2 = 3'd1,
        SRC_REG3 = 3'd2,
        SRC_REG4 = 3'd3,
        SRC_SEG  = 3'd4,
        SRC_MEM  = 3'd5,
        SRC_IMM  = 3'd6,
        SRC_EIP  = 3'd7
    } op_src_t;

    typedef enum logic [1:0] {
        DEST_NONE = 2'd0,
        DEST_REG  = 2'd1,
        DEST_SEG  = 2'd2,
        DEST_MEM  = 2'd3
    } dest_kind_t;

    // access size, 1 to 8 bytes.
    typedef enum logic [1:0] {
        SZ_BYTE  = 2'd0,
        SZ_WORD  = 2'd1,
        SZ_DWORD = 2'd2,
        SZ_QWORD = 2'd3
    } opsize_t;

    typedef struct packed {
        logic       page_fault;
        logic       prot_fault;
        logic [1:0] other;
    } exc_t;

endpackage

`default_nettype wire

// File: dcache/tlb_entries.sv
`timescale 1ns/1ns
`default_nettype none
`include "mem_defs.svh"

module tlb_entries (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       cfg_we,
    input  logic [$clog2(`MEM_TLB_ENTRIES)-1:0]        cfg_idx,
    input  logic [`MEM_PAGE_W-1:0]                     cfg_vp,
    input  logic [`MEM_PAGE_W-1:0]                     cfg_pf,
    input  logic                                       cfg_present,
    input  logic                                       cfg_rw,
    output logic [`MEM_TLB_ENTRIES-1:0][`MEM_PAGE_W-1:0] entry_vp,
    output logic [`MEM_TLB_ENTRIES-1:0][`MEM_PAGE_W-1:0] entry_pf,
    output logic [`MEM_TLB_ENTRIES-1:0]                entry_present,
    output logic [`MEM_TLB_ENTRIES-1:0]                entry_rw
);

    // an entry takes part in lookups only once its present bit is set.
    always_ff @(posedge clk) begin
        if (rst)
            entry_present <= '0;
        else if (cfg_we)
            entry_present[cfg_idx] <= cfg_present;
    end

    always_ff @(posedge clk) begin
        if (cfg_we) begin
            entry_vp[cfg_idx] <= cfg_vp;
            entry_pf[cfg_idx] <= cfg_pf;
            entry_rw[cfg_idx] <= cfg_rw;
        end
    end

endmodule

`default_nettype wire

// File: dcache/tlb.sv
`timescale 1ns/1ns
`default_nettype none
`include "mem_defs.svh"

module tlb (
    input  logic [`MEM_ADDR_W-1:0]                     vaddr,
    input  logic                                       is_write,
    input  logic [`MEM_TLB_ENTRIES-1:0][`MEM_PAGE_W-1:0] entry_vp,
    input  logic [`MEM_TLB_ENTRIES-1:0][`MEM_PAGE_W-1:0] entry_pf,
    input  logic [`MEM_TLB_ENTRIES-1:0]                entry_present,
    input  logic [`MEM_TLB_ENTRIES-1:0]                entry_rw,
    output logic [`MEM_ADDR_W-1:0]                     phys_addr,
    output logic                                       page_fault,
    output logic                                       prot_fault
);
    localparam int IDX_W = $clog2(`MEM_TLB_ENTRIES);
    localparam int OFF_W = `MEM_ADDR_W - `MEM_PAGE_W;

    logic [`MEM_PAGE_W-1:0] vpage;
    logic [IDX_W-1:0]       hit_idx;
    logic                   tlb_hit;

    assign vpage = vaddr[`MEM_ADDR_W-1 -: `MEM_PAGE_W];

    // scan downward so the lowest matching entry is the one kept.
    always_comb begin
        tlb_hit = 1'b0;
        hit_idx = '0;
        for (int i = `MEM_TLB_ENTRIES - 1; i >= 0; i--) begin
            if (entry_present[i] && entry_vp[i] == vpage) begin
                tlb_hit = 1'b1;
                hit_idx = IDX_W'(i);
            end
        end
    end

    assign phys_addr  = {tlb_hit ? entry_pf[hit_idx] : vpage, vaddr[OFF_W-1:0]};
    assign page_fault = !tlb_hit;
    assign prot_fault = tlb_hit && is_write && !entry_rw[hit_idx];

endmodule

`default_nettype wire

// File: dcache/dcache.sv
`timescale 1ns/1ns
`default_nettype none
`include "mem_defs.svh"

module dcache (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rd_en,
    input  logic [`MEM_ADDR_W-1:0] paddr,
    input  mem_pkg::opsize_t       size,
    output logic [`MEM_DATA_W-1:0] rd_data,
    output logic                   hit,
    output logic                   cache_stall,
    output logic                   fill_req,
    output logic [`MEM_ADDR_W-1:0] fill_addr,
    input  logic                   fill_valid,
    input  logic [`MEM_DATA_W-1:0] fill_data,
    input  logic                   wb_valid,
    input  logic [`MEM_ADDR_W-1:0] wb_addr,
    input  logic [`MEM_DATA_W-1:0] wb_data,
    input  mem_pkg::opsize_t       wb_size,
    output logic                   mem_wr_valid,
    output logic [`MEM_ADDR_W-1:0] mem_wr_addr,
    output logic [`MEM_DATA_W-1:0] mem_wr_data,
    output mem_pkg::opsize_t       mem_wr_size
);
    import mem_pkg::*;

    localparam int BYTES = `MEM_DATA_W / 8;
    localparam int OFF_W = $clog2(BYTES);
    localparam int IDX_W = $clog2(`MEM_LINES);
    localparam int TAG_W = `MEM_ADDR_W - IDX_W - OFF_W;

    typedef enum logic {S_IDLE, S_WAIT} miss_state_e;

    function automatic logic [BYTES-1:0] size_mask(opsize_t sz);
        case (sz)
            SZ_BYTE:  return BYTES'(8'h01);
            SZ_WORD:  return BYTES'(8'h03);
            SZ_DWORD: return BYTES'(8'h0f);
            default:  return '1;
        endcase
    endfunction

    function automatic logic [`MEM_DATA_W-1:0] byte_merge(logic [`MEM_DATA_W-1:0] old_line,
                                                          logic [`MEM_DATA_W-1:0] new_line,
                                                          logic [BYTES-1:0] be);
        logic [`MEM_DATA_W-1:0] res;
        for (int b = 0; b < BYTES; b++)
            res[b*8 +: 8] = be[b] ? new_line[b*8 +: 8] : old_line[b*8 +: 8];
        return res;
    endfunction

    miss_state_e            state_q;
    logic [`MEM_LINES-1:0]  valid_q;
    logic [TAG_W-1:0]       tag_q [`MEM_LINES];
    logic [`MEM_DATA_W-1:0] data_q [`MEM_LINES];

    logic [IDX_W-1:0]       rd_idx, wb_idx, fill_idx;
    logic [TAG_W-1:0]       wb_tag, fill_tag;
    logic [OFF_W-1:0]       wb_off;
    logic [BYTES-1:0]       wb_be;
    logic [`MEM_DATA_W-1:0] wb_line, rd_line;
    logic [2*BYTES-1:0]     rd_span;
    logic                   miss, fill_we, wb_same, wb_hit;

    assign rd_idx  = paddr[OFF_W +: IDX_W];
    assign hit     = valid_q[rd_idx] && (tag_q[rd_idx] == paddr[`MEM_ADDR_W-1 -: TAG_W]);
    assign miss    = rd_en && !hit;
    assign rd_span = {{BYTES{1'b0}}, size_mask(size)} << paddr[OFF_W-1:0];

    // shift the addressed bytes down and zero-extend to the access size.
    always_comb begin
        rd_line = data_q[rd_idx] >> {paddr[OFF_W-1:0], 3'b000};
        rd_data = rd_line & byte_merge('0, '1, size_mask(size));
    end

    assign cache_stall = (state_q == S_WAIT) || miss;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= S_IDLE;
            fill_req <= 1'b0;
        end else begin
            fill_req <= 1'b0;
            case (state_q)
                S_IDLE: if (miss) begin
                    state_q  <= S_WAIT;
                    fill_req <= 1'b1;
                end
                default: if (fill_valid) state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && miss)
            fill_addr <= {paddr[`MEM_ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
    end

    assign fill_idx = fill_addr[OFF_W +: IDX_W];
    assign fill_tag = fill_addr[`MEM_ADDR_W-1 -: TAG_W];
    assign fill_we  = fill_valid && (state_q == S_WAIT);

    assign wb_idx  = wb_addr[OFF_W +: IDX_W];
    assign wb_tag  = wb_addr[`MEM_ADDR_W-1 -: TAG_W];
    assign wb_off  = wb_addr[OFF_W-1:0];
    assign wb_be   = size_mask(wb_size) << wb_off;
    assign wb_line = wb_data << {wb_off, 3'b000};
    assign wb_same = wb_valid && (wb_idx == fill_idx) && (wb_tag == fill_tag);
    assign wb_hit  = wb_valid && valid_q[wb_idx] && (tag_q[wb_idx] == wb_tag);

    always_ff @(posedge clk) begin
        if (rst)
            valid_q <= '0;
        else if (fill_we)
            valid_q[fill_idx] <= 1'b1;
    end

    // a writeback to the line being filled lands on top of the fill data.
    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_q[fill_idx]  <= fill_tag;
            data_q[fill_idx] <= wb_same ? byte_merge(fill_data, wb_line, wb_be) : fill_data;
        end
        if (wb_hit && !(fill_we && wb_idx == fill_idx))
            data_q[wb_idx] <= byte_merge(data_q[wb_idx], wb_line, wb_be);
    end

    // write-through, with no allocate on a miss.
    always_ff @(posedge clk) begin
        if (rst)
            mem_wr_valid <= 1'b0;
        else
            mem_wr_valid <= wb_valid;
    end

    always_ff @(posedge clk) begin
        if (wb_valid) begin
            mem_wr_addr <= wb_addr;
            mem_wr_data <= wb_data;
            mem_wr_size <= wb_size;
        end
    end

    a_no_line_cross: assert property (@(posedge clk) disable iff (rst)
        rd_en |-> (rd_span[2*BYTES-1:BYTES] == '0));

    a_fill_when_waiting: assert property (@(posedge clk) disable iff (rst)
        fill_valid |-> (state_q == S_WAIT));

endmodule

`default_nettype wire

// File: verilog/opswap.sv
`timescale 1ns/1ns
`default_nettype none
`include "mem_defs.svh"

module opswap (
    input  mem_pkg::op_src_t       op1_sel,
    input  mem_pkg::op_src_t       op2_sel,
    input  mem_pkg::dest_kind_t    dest_kind,
    input  logic [2:0]             dest_reg,
    input  logic [`MEM_ADDR_W-1:0] mem_addr,
    input  logic [`MEM_DATA_W-1:0] reg1,
    input  logic [`MEM_DATA_W-1:0] reg2,
    input  logic [`MEM_DATA_W-1:0] reg3,
    input  logic [`MEM_DATA_W-1:0] reg4,
    input  logic [15:0]            seg,
    input  logic [`MEM_DATA_W-1:0] imm,
    input  logic [`MEM_ADDR_W-1:0] eip,
    input  logic [`MEM_DATA_W-1:0] mem_data,
    output logic [`MEM_DATA_W-1:0] op1_val,
    output logic [`MEM_DATA_W-1:0] op2_val,
    output logic [`MEM_ADDR_W-1:0] dest_addr
);
    import mem_pkg::*;

    function automatic logic [`MEM_DATA_W-1:0] src_mux(op_src_t sel);
        logic [`MEM_DATA_W-1:0] val;
        case (sel)
            SRC_REG1: val = reg1;
            SRC_REG2: val = reg2;
            SRC_REG3: val = reg3;
            SRC_REG4: val = reg4;
            SRC_SEG:  val = {{(`MEM_DATA_W-16){1'b0}}, seg};
            SRC_MEM:  val = mem_data;
            SRC_IMM:  val = imm;
            default:  val = {{(`MEM_DATA_W-`MEM_ADDR_W){1'b0}}, eip};
        endcase
        return val;
    endfunction

    always_comb begin
        op1_val = src_mux(op1_sel);
        op2_val = src_mux(op2_sel);
    end

    // register and segment destinations carry their index.
    always_comb begin
        if (dest_kind == DEST_MEM)
            dest_addr = mem_addr;
        else
            dest_addr = {{(`MEM_ADDR_W-3){1'b0}}, dest_reg};
    end

endmodule

`default_nettype wire

// File: verilog/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "mem_defs.svh"

module mem_stage (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              valid_in,
    input  mem_pkg::opsize_t                  opsize_in,
    input  logic [3:0]                        memsize_ovr,
    input  logic [`MEM_ADDR_W-1:0]            mem_addr,
    input  logic                              mem_rw,
    input  logic [`MEM_DATA_W-1:0]            reg1, reg2, reg3, reg4,
    input  logic [`MEM_DATA_W-1:0]            seg,
    input  logic [`MEM_DATA_W-1:0]            imm,
    input  logic [`MEM_ADDR_W-1:0]            eip_in,
    input  mem_pkg::op_src_t                  op1_sel, op2_sel,
    input  mem_pkg::dest_kind_t               dest_kind_in,
    input  logic [2:0]                        dest_reg_in,
    input  logic [`MEM_CTRL_W-1:0]            ctrl_in,
    input  logic                              ie_in,
    input  mem_pkg::exc_t                     exc_in,
    input  logic                              fwd_stall,
    output logic                              stall,
    input  logic                              cfg_we,
    input  logic [$clog2(`MEM_TLB_ENTRIES)-1:0] cfg_idx,
    input  logic [`MEM_PAGE_W-1:0]            cfg_vp,
    input  logic [`MEM_PAGE_W-1:0]            cfg_pf,
    input  logic                              cfg_present,
    input  logic                              cfg_rw,
    output logic                              fill_req,
    output logic [`MEM_ADDR_W-1:0]            fill_addr,
    input  logic                              fill_valid,
    input  logic [`MEM_DATA_W-1:0]            fill_data,
    input  logic                              wb_valid,
    input  logic [`MEM_ADDR_W-1:0]            wb_addr,
    input  logic [`MEM_DATA_W-1:0]            wb_data,
    input  mem_pkg::opsize_t                  wb_size,
    output logic                              mem_wr_valid,
    output logic [`MEM_ADDR_W-1:0]            mem_wr_addr,
    output logic [`MEM_DATA_W-1:0]            mem_wr_data,
    output mem_pkg::opsize_t                  mem_wr_size,
    output logic                              valid_out,
    output logic [`MEM_DATA_W-1:0]            op1_val,
    output logic [`MEM_DATA_W-1:0]            op2_val,
    output mem_pkg::dest_kind_t               dest_kind_out,
    output logic [`MEM_ADDR_W-1:0]            dest_addr,
    output mem_pkg::opsize_t                  opsize_out,
    output logic [`MEM_CTRL_W-1:0]            ctrl_out,
    output logic                              ie_out,
    output mem_pkg::exc_t                     exc_out
);
    import mem_pkg::*;

    logic [`MEM_TLB_ENTRIES-1:0][`MEM_PAGE_W-1:0] entry_vp;
    logic [`MEM_TLB_ENTRIES-1:0][`MEM_PAGE_W-1:0] entry_pf;
    logic [`MEM_TLB_ENTRIES-1:0]                  entry_present;
    logic [`MEM_TLB_ENTRIES-1:0]                  entry_rw;

    logic [`MEM_ADDR_W-1:0] phys_addr;
    logic [`MEM_DATA_W-1:0] rd_data;
    logic [`MEM_DATA_W-1:0] op1_nxt, op2_nxt;
    logic [`MEM_ADDR_W-1:0] dest_nxt;
    logic tlb_page_fault, tlb_prot_fault;
    logic cache_stall;
    logic src_mem, mem_access, page_fault, prot_fault, rd_en;
    opsize_t eff_size;
    exc_t exc_nxt;

    // an all-zero override keeps the decoded size.
    always_comb begin
        eff_size = opsize_in;
        if (memsize_ovr[0])
            eff_size = SZ_BYTE;
        else if (memsize_ovr[1])
            eff_size = SZ_WORD;
        else if (memsize_ovr[2])
            eff_size = SZ_DWORD;
        else if (memsize_ovr[3])
            eff_size = SZ_QWORD;
    end

    assign src_mem    = (op1_sel == SRC_MEM) || (op2_sel == SRC_MEM);
    assign mem_access = valid_in && (src_mem || dest_kind_in == DEST_MEM);
    assign page_fault = mem_access && tlb_page_fault;
    assign prot_fault = mem_access && tlb_prot_fault;
    assign rd_en      = valid_in && src_mem && !page_fault && !prot_fault;
    assign stall      = cache_stall || fwd_stall;

    always_comb begin
        exc_nxt            = exc_in;
        exc_nxt.page_fault = page_fault;
        exc_nxt.prot_fault = prot_fault;
    end

    tlb_entries u_tlb_entries (
        .clk(clk), .rst(rst),
        .cfg_we(cfg_we), .cfg_idx(cfg_idx), .cfg_vp(cfg_vp), .cfg_pf(cfg_pf),
        .cfg_present(cfg_present), .cfg_rw(cfg_rw),
        .entry_vp(entry_vp), .entry_pf(entry_pf),
        .entry_present(entry_present), .entry_rw(entry_rw)
    );

    tlb u_tlb (
        .vaddr(mem_addr), .is_write(mem_rw),
        .entry_vp(entry_vp), .entry_pf(entry_pf),
        .entry_present(entry_present), .entry_rw(entry_rw),
        .phys_addr(phys_addr), .page_fault(tlb_page_fault), .prot_fault(tlb_prot_fault)
    );

    dcache u_dcache (
        .clk(clk), .rst(rst),
        .rd_en(rd_en), .paddr(phys_addr), .size(eff_size),
        .rd_data(rd_data), .hit(), .cache_stall(cache_stall),
        .fill_req(fill_req), .fill_addr(fill_addr),
        .fill_valid(fill_valid), .fill_data(fill_data),
        .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data), .wb_size(wb_size),
        .mem_wr_valid(mem_wr_valid), .mem_wr_addr(mem_wr_addr),
        .mem_wr_data(mem_wr_data), .mem_wr_size(mem_wr_size)
    );

    // segment selectors are 16 bits wide.
    opswap u_opswap (
        .op1_sel(op1_sel), .op2_sel(op2_sel), .dest_kind(dest_kind_in),
        .dest_reg(dest_reg_in), .mem_addr(mem_addr),
        .reg1(reg1), .reg2(reg2), .reg3(reg3), .reg4(reg4),
        .seg(seg[15:0]), .imm(imm), .eip(eip_in), .mem_data(rd_data),
        .op1_val(op1_nxt), .op2_val(op2_nxt), .dest_addr(dest_nxt)
    );

    // a cache miss inserts a bubble and fwd_stall freezes the register.
    always_ff @(posedge clk) begin
        if (rst)
            valid_out <= 1'b0;
        else if (!fwd_stall)
            valid_out <= valid_in && !cache_stall;
    end

    always_ff @(posedge clk) begin
        if (!fwd_stall) begin
            op1_val       <= op1_nxt;
            op2_val       <= op2_nxt;
            dest_kind_out <= dest_kind_in;
            dest_addr     <= dest_nxt;
            opsize_out    <= eff_size;
            ctrl_out      <= ctrl_in;
            ie_out        <= ie_in || page_fault || prot_fault;
            exc_out       <= exc_nxt;
        end
    end

    a_ovr_onehot: assert property (@(posedge clk) disable iff (rst)
        valid_in |-> $onehot0(memsize_ovr));

endmodule

`default_nettype wire

// File: dv/tb_mem_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "mem_defs.svh"

module tb_mem_stage;
    import mem_pkg::*;

    typedef struct {
        opsize_t    opsize;
        logic [3:0] ovr;
        logic [31:0] vaddr;
        logic       rw;
        op_src_t    op1_sel;
        op_src_t    op2_sel;
        dest_kind_t dest_kind;
        logic [2:0] dest_reg;
        logic       ie;
        logic [1:0] other;
        int         hold;
        opsize_t    exp_size;
        logic       exp_pf;
        logic       exp_prf;
        int         exp_fills;
    } row_t;

    logic clk = 1'b0;
    logic rst;
    logic valid_in, mem_rw, ie_in, fwd_stall, stall;
    opsize_t opsize_in, wb_size, mem_wr_size, opsize_out;
    logic [3:0] memsize_ovr;
    logic [`MEM_ADDR_W-1:0] mem_addr, eip_in, fill_addr, wb_addr, mem_wr_addr, dest_addr;
    logic [`MEM_DATA_W-1:0] reg1, reg2, reg3, reg4, seg, imm, fill_data, wb_data;
    logic [`MEM_DATA_W-1:0] mem_wr_data, op1_val, op2_val;
    op_src_t op1_sel, op2_sel;
    dest_kind_t dest_kind_in, dest_kind_out;
    logic [2:0] dest_reg_in;
    logic [`MEM_CTRL_W-1:0] ctrl_in, ctrl_out;
    exc_t exc_in, exc_out;
    logic cfg_we, cfg_present, cfg_rw, fill_req, fill_valid, wb_valid, mem_wr_valid;
    logic valid_out, ie_out;
    logic [2:0] cfg_idx;
    logic [`MEM_PAGE_W-1:0] cfg_vp, cfg_pf;

    logic [63:0] mem_model [logic [31:0]];
    logic [19:0] map_vp [$];
    logic [19:0] map_pf [$];
    row_t rows [$];
    int errors = 0;
    int row_errors;
    int failed_rows = 0;
    int fill_count = 0;
    logic [31:0] last_fill_addr;

    mem_stage dut0 (.*);

    always #5 clk = ~clk;

    // lines never written hold a pattern built from their address.
    function automatic logic [63:0] model_line(logic [31:0] a);
        if (mem_model.exists(a))
            return mem_model[a];
        return {a ^ 32'hc3a5_0f96, a};
    endfunction

    function automatic logic [31:0] to_phys(logic [31:0] va);
        for (int i = 0; i < map_vp.size(); i++)
            if (map_vp[i] == va[31:12])
                return {map_pf[i], va[11:0]};
        return va;
    endfunction

    function automatic logic [63:0] read_expect(logic [31:0] va, opsize_t sz);
        logic [31:0] pa;
        logic [63:0] v;
        pa = to_phys(va);
        v = model_line({pa[31:3], 3'b000}) >> (pa[2:0] * 8);
        if (sz != SZ_QWORD)
            v = v & ((64'd1 << (8 * (1 << sz))) - 1);
        return v;
    endfunction

    function automatic logic [63:0] src_expect(op_src_t sel, logic [63:0] mem_val);
        case (sel)
            SRC_REG1: return reg1;
            SRC_REG2: return reg2;
            SRC_REG3: return reg3;
            SRC_REG4: return reg4;
            SRC_SEG:  return {48'd0, seg[15:0]};
            SRC_MEM:  return mem_val;
            SRC_IMM:  return imm;
            default:  return {32'd0, eip_in};
        endcase
    endfunction

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
            row_errors++;
        end
    endtask

    task automatic check_data(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
            row_errors++;
        end
    endtask

    task automatic check_size(string name, opsize_t got, opsize_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
            row_errors++;
        end
    endtask

    task automatic check_dest(dest_kind_t gk, dest_kind_t ek, logic [31:0] ga, logic [31:0] ea);
        if (gk !== ek) begin
            $display("[FAIL] dest_kind_out got %h expected %h", gk, ek);
            errors++;
            row_errors++;
        end
        if (ga !== ea) begin
            $display("[FAIL] dest_addr got %h expected %h", ga, ea);
            errors++;
            row_errors++;
        end
    endtask

    task automatic check_exc(exc_t ge, exc_t ee, logic gie, logic eie);
        if (ge !== ee) begin
            $display("[FAIL] exc_out got %h expected %h", ge, ee);
            errors++;
            row_errors++;
        end
        if (gie !== eie) begin
            $display("[FAIL] ie_out got %h expected %h", gie, eie);
            errors++;
            row_errors++;
        end
    endtask

    // memory model answers each fill after a random delay.
    always begin
        int delay;
        @(negedge clk);
        if (fill_req) begin
            fill_count++;
            last_fill_addr = fill_addr;
            delay = 1 + ($urandom % 6);
            repeat (delay) @(negedge clk);
            fill_data  = model_line(last_fill_addr);
            fill_valid = 1'b1;
            @(negedge clk);
            fill_valid = 1'b0;
        end
    end

    always @(negedge clk) begin
        logic [63:0] line;
        if (mem_wr_valid) begin
            line = model_line({mem_wr_addr[31:3], 3'b000});
            for (int b = 0; b < (1 << mem_wr_size); b++)
                line[(mem_wr_addr[2:0] + b) * 8 +: 8] = mem_wr_data[b * 8 +: 8];
            mem_model[{mem_wr_addr[31:3], 3'b000}] = line;
        end
    end

    task automatic map_page(int idx, logic [19:0] vp, logic [19:0] pf, logic rw);
        cfg_we      = 1'b1;
        cfg_idx     = idx[2:0];
        cfg_vp      = vp;
        cfg_pf      = pf;
        cfg_present = 1'b1;
        cfg_rw      = rw;
        @(negedge clk);
        cfg_we = 1'b0;
        map_vp.push_back(vp);
        map_pf.push_back(pf);
    endtask

    task automatic write_back(logic [31:0] pa, logic [63:0] data, opsize_t sz);
        row_errors = 0;
        wb_valid = 1'b1;
        wb_addr  = pa;
        wb_data  = data;
        wb_size  = sz;
        @(negedge clk);
        wb_valid = 1'b0;
        check_bit("mem_wr_valid", mem_wr_valid, 1'b1);
        check_data("mem_wr_addr", {32'd0, mem_wr_addr}, {32'd0, pa});
        check_data("mem_wr_data", mem_wr_data, data);
        check_size("mem_wr_size", mem_wr_size, sz);
        if (row_errors != 0)
            failed_rows++;
        $display("write %h: %s", pa, (row_errors == 0) ? "ok" : "mismatch");
    endtask

    function automatic row_t mk(opsize_t sz, logic [3:0] ovr, logic [31:0] va, logic rw,
                                op_src_t s1, op_src_t s2, dest_kind_t dk, logic [2:0] dr,
                                logic ie, logic [1:0] oth, int hold, opsize_t esz,
                                logic epf, logic eprf, int efill);
        row_t r;
        r.opsize    = sz;
        r.ovr       = ovr;
        r.vaddr     = va;
        r.rw        = rw;
        r.op1_sel   = s1;
        r.op2_sel   = s2;
        r.dest_kind = dk;
        r.dest_reg  = dr;
        r.ie        = ie;
        r.other     = oth;
        r.hold      = hold;
        r.exp_size  = esz;
        r.exp_pf    = epf;
        r.exp_prf   = eprf;
        r.exp_fills = efill;
        return r;
    endfunction

    task automatic apply_row(int i, row_t r);
        logic [63:0] mem_val, s_op1, s_op2;
        logic [31:0] exp_dest, s_dest;
        logic [`MEM_CTRL_W-1:0] s_ctrl;
        dest_kind_t s_kind;
        opsize_t s_size;
        exc_t exp_exc, s_exc;
        logic s_ie;
        logic faulted;
        int cycles, fills_before;
        row_errors   = 0;
        fills_before = fill_count;
        mem_val      = read_expect(r.vaddr, r.exp_size);
        s_op1  = op1_val;
        s_op2  = op2_val;
        s_kind = dest_kind_out;
        s_dest = dest_addr;
        s_size = opsize_out;
        s_exc  = exc_out;
        s_ie   = ie_out;
        s_ctrl = ctrl_out;
        valid_in     = 1'b1;
        opsize_in    = r.opsize;
        memsize_ovr  = r.ovr;
        mem_addr     = r.vaddr;
        mem_rw       = r.rw;
        op1_sel      = r.op1_sel;
        op2_sel      = r.op2_sel;
        dest_kind_in = r.dest_kind;
        dest_reg_in  = r.dest_reg;
        ie_in        = r.ie;
        exc_in       = {2'b00, r.other};
        ctrl_in      = 32'h0c00_0000 + i;
        fwd_stall    = (r.hold > 0);
        // the output register must not move while fwd_stall is high.
        for (int k = 0; k < r.hold; k++) begin
            @(negedge clk);
            check_bit("stall", stall, 1'b1);
            check_bit("valid_out", valid_out, 1'b0);
            check_data("op1_val", op1_val, s_op1);
            check_data("op2_val", op2_val, s_op2);
            check_dest(dest_kind_out, s_kind, dest_addr, s_dest);
            check_size("opsize_out", opsize_out, s_size);
            check_exc(exc_out, s_exc, ie_out, s_ie);
            check_data("ctrl_out", {32'd0, ctrl_out}, {32'd0, s_ctrl});
        end
        fwd_stall = 1'b0;
        cycles = 0;
        while (!valid_out) begin
            @(negedge clk);
            cycles++;
            if (cycles == 1 && r.exp_fills > 0) begin
                check_bit("stall", stall, 1'b1);
                check_bit("fill_req", fill_req, 1'b1);
            end
            if (!valid_out && cycles >= 200) begin
                $display("timeout: row %0d never produced valid_out", i);
                $display("Simulation finished: FAIL");
                $finish;
            end
        end
        if (r.exp_fills == 0 && r.hold == 0 && cycles != 1) begin
            $display("row %0d took %0d cycles instead of one", i, cycles);
            errors++;
            row_errors++;
        end
        if (fill_count - fills_before != r.exp_fills) begin
            $display("row %0d issued %0d fills, %0d expected", i,
                     fill_count - fills_before, r.exp_fills);
            errors++;
            row_errors++;
        end
        if (r.exp_fills > 0) begin
            logic [31:0] pa;
            pa = to_phys(r.vaddr);
            check_data("fill_addr", {32'd0, last_fill_addr}, {32'd0, pa[31:3], 3'b000});
        end
        exp_dest = (r.dest_kind == DEST_MEM) ? r.vaddr : {29'd0, r.dest_reg};
        exp_exc  = {r.exp_pf, r.exp_prf, r.other};
        faulted  = r.exp_pf || r.exp_prf;
        // a faulted access leaves the loaded value undefined.
        if (!faulted || r.op1_sel != SRC_MEM)
            check_data("op1_val", op1_val, src_expect(r.op1_sel, mem_val));
        if (!faulted || r.op2_sel != SRC_MEM)
            check_data("op2_val", op2_val, src_expect(r.op2_sel, mem_val));
        check_dest(dest_kind_out, r.dest_kind, dest_addr, exp_dest);
        check_size("opsize_out", opsize_out, r.exp_size);
        check_exc(exc_out, exp_exc, ie_out, r.ie | r.exp_pf | r.exp_prf);
        check_data("ctrl_out", {32'd0, ctrl_out}, {32'd0, 32'h0c00_0000 + i});
        valid_in = 1'b0;
        @(negedge clk);
        if (row_errors != 0)
            failed_rows++;
        $display("row %0d: %s", i, (row_errors == 0) ? "ok" : "mismatch");
    endtask

    initial begin
        void'($urandom(32'h1303_3008));
        rst          = 1'b1;
        valid_in     = 1'b0;
        opsize_in    = SZ_BYTE;
        memsize_ovr  = 4'd0;
        mem_addr     = '0;
        mem_rw       = 1'b0;
        eip_in       = 32'h0040_1000;
        reg1         = 64'h1111_2222_3333_4444;
        reg2         = 64'h5555_6666_7777_8888;
        reg3         = 64'h9999_aaaa_bbbb_cccc;
        reg4         = 64'hdddd_eeee_ffff_0101;
        seg          = 64'h7700_0000_0000_5e61;
        imm          = 64'hfedc_ba98_7654_3210;
        op1_sel      = SRC_REG1;
        op2_sel      = SRC_REG1;
        dest_kind_in = DEST_NONE;
        dest_reg_in  = 3'd0;
        ctrl_in      = '0;
        ie_in        = 1'b0;
        exc_in       = '0;
        fwd_stall    = 1'b0;
        cfg_we       = 1'b0;
        cfg_idx      = '0;
        cfg_vp       = '0;
        cfg_pf       = '0;
        cfg_present  = 1'b0;
        cfg_rw       = 1'b0;
        fill_valid   = 1'b0;
        fill_data    = '0;
        wb_valid     = 1'b0;
        wb_addr      = '0;
        wb_data      = '0;
        wb_size      = SZ_BYTE;

        rows.push_back(mk(SZ_DWORD, 4'b0000, 32'h0, 0, SRC_REG1, SRC_REG2, DEST_REG, 3,
                          0, 2'b00, 0, SZ_DWORD, 0, 0, 0));
        rows.push_back(mk(SZ_QWORD, 4'b0001, 32'h0, 0, SRC_SEG, SRC_IMM, DEST_SEG, 2,
                          0, 2'b01, 0, SZ_BYTE, 0, 0, 0));
        rows.push_back(mk(SZ_BYTE, 4'b1000, 32'h0, 0, SRC_EIP, SRC_REG3, DEST_NONE, 5,
                          1, 2'b00, 0, SZ_QWORD, 0, 0, 0));
        rows.push_back(mk(SZ_BYTE, 4'b0100, 32'h0, 0, SRC_REG4, SRC_REG1, DEST_REG, 7,
                          0, 2'b00, 0, SZ_DWORD, 0, 0, 0));
        rows.push_back(mk(SZ_WORD, 4'b0010, 32'h0, 0, SRC_REG2, SRC_EIP, DEST_REG, 1,
                          0, 2'b00, 0, SZ_WORD, 0, 0, 0));
        rows.push_back(mk(SZ_DWORD, 4'b0000, 32'h0001_0004, 0, SRC_MEM, SRC_REG1, DEST_REG,
                          4, 0, 2'b00, 0, SZ_DWORD, 0, 0, 1));
        rows.push_back(mk(SZ_WORD, 4'b0000, 32'h0001_0002, 0, SRC_IMM, SRC_MEM, DEST_REG,
                          6, 0, 2'b00, 0, SZ_WORD, 0, 0, 0));
        rows.push_back(mk(SZ_QWORD, 4'b0000, 32'h0001_1008, 0, SRC_MEM, SRC_SEG, DEST_MEM,
                          0, 0, 2'b00, 0, SZ_QWORD, 0, 0, 1));
        rows.push_back(mk(SZ_DWORD, 4'b0000, 32'h0003_0000, 1, SRC_MEM, SRC_REG2, DEST_MEM,
                          0, 0, 2'b10, 0, SZ_DWORD, 1, 0, 0));
        rows.push_back(mk(SZ_DWORD, 4'b0000, 32'h0001_1010, 1, SRC_MEM, SRC_REG4, DEST_MEM,
                          0, 0, 2'b01, 0, SZ_DWORD, 0, 1, 0));
        // these follow the writebacks.
        rows.push_back(mk(SZ_DWORD, 4'b0000, 32'h0001_0004, 0, SRC_MEM, SRC_REG2, DEST_REG,
                          2, 0, 2'b00, 0, SZ_DWORD, 0, 0, 0));
        rows.push_back(mk(SZ_WORD, 4'b0000, 32'h0, 0, SRC_REG3, SRC_IMM, DEST_SEG, 1,
                          1, 2'b11, 4, SZ_WORD, 0, 0, 0));
        rows.push_back(mk(SZ_BYTE, 4'b0000, 32'h0001_0101, 0, SRC_REG1, SRC_MEM, DEST_REG,
                          3, 0, 2'b00, 0, SZ_BYTE, 0, 0, 1));

        repeat (3) @(negedge clk);
        rst = 1'b0;
        row_errors = 0;
        check_bit("valid_out", valid_out, 1'b0);
        check_bit("fill_req", fill_req, 1'b0);
        check_bit("mem_wr_valid", mem_wr_valid, 1'b0);
        check_bit("stall", stall, 1'b0);
        $display("reset: %s", (row_errors == 0) ? "ok" : "mismatch");
        if (row_errors != 0)
            failed_rows++;

        map_page(0, 20'h00010, 20'h00020, 1'b1);
        map_page(1, 20'h00011, 20'h00021, 1'b0);

        for (int i = 0; i < rows.size(); i++) begin
            if (i == 10) begin
                write_back(32'h0002_0004, 64'h0000_0000_0000_a5c3, SZ_WORD);
                write_back(32'h0002_0100, 64'h0000_0000_7e3d_19b4, SZ_DWORD);
            end
            apply_row(i, rows[i]);
        end

        $display("rows %0d, failed %0d, errors %0d", rows.size(), failed_rows, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+common
common/mem_pkg.sv
dcache/tlb_entries.sv
dcache/tlb.sv
dcache/dcache.sv
verilog/opswap.sv
verilog/mem_stage.sv
dv/tb_mem_stage.sv
